/* flist.f */
rtl/arcade_pkg.sv
rtl/arcade_cfg_regs.sv
rtl/rom_loader.sv
rtl/rom_store.sv
rtl/input_mapper.sv
rtl/audio_dac.sv
rtl/arcade_shell_top.sv
test/tb_arcade_shell.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_arcade_shell
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/10ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator and run it"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)

/* test/tb_arcade_shell.sv */
`timescale 1ns/10ps

module tb_arcade_shell;
	import arcade_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int N_REG_OPS = 40;
	localparam int N_BYTES = 400;
	localparam int N_PANELS = 30;
	localparam int N_SAMPLES = 3;
	localparam int AUDIO_PHASE = 65536;
	localparam int HS_LIMIT = 16; // Cycles allowed for one AXI handshake.
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_REG_OPS * 8 + N_BYTES * 7
		+ N_PANELS * 4 + N_SAMPLES * AUDIO_PHASE + 2000;

	logic clk_sys = 1'b0;
	logic rst;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	dl_byte_t dl;
	logic [ROM_ADDR_W-1:0] rom_addr;
	logic [7:0] rom_data;
	panel_t panel;
	inp_bytes_t inp;
	logic [7:0] dsw0;
	logic [7:0] dsw1;
	logic core_reset;
	logic [AUDIO_W-1:0] sample;
	logic audio_out;

	// Reference model.
	logic m_status = 1'b0;
	logic [15:0] m_dsw = '0;
	logic m_mode = 1'b0;
	logic m_loaded = 1'b0;
	logic [AUDIO_W-1:0] m_acc = '0;
	logic [7:0] img [2**ROM_ADDR_W];
	bit img_set [2**ROM_ADDR_W];
	int unsigned img_addrs[$];

	arcade_shell_top UUT (
		.clk_sys(clk_sys),
		.rst(rst),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.dl(dl),
		.rom_addr(rom_addr),
		.rom_data(rom_data),
		.panel(panel),
		.inp(inp),
		.dsw0(dsw0),
		.dsw1(dsw1),
		.core_reset(core_reset),
		.sample(sample),
		.audio_out(audio_out)
	);

	always #10 clk_sys = ~clk_sys;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_inp(input string name, input inp_bytes_t got, input inp_bytes_t exp);
		if (got !== exp) abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
		if (got !== exp) abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic model_write(input logic [3:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output axi_resp_e resp);
		resp = OKAY;
		case (addr)
			REG_STATUS: if (strb[0]) m_status = data[0];
			REG_DSW: begin
				if (strb[0]) m_dsw[7:0] = data[7:0];
				if (strb[1]) m_dsw[15:8] = data[15:8];
			end
			REG_MODE: if (strb[0]) m_mode = data[0];
			default: resp = SLVERR;
		endcase
	endtask

	task automatic model_read(input logic [3:0] addr, output logic [31:0] data,
		output axi_resp_e resp);
		data = '0;
		resp = OKAY;
		case (addr)
			REG_STATUS: data[0] = m_status;
			REG_DSW: data[15:0] = m_dsw;
			REG_MODE: data[0] = m_mode;
			REG_INFO: data[1:0] = {dl.active, m_loaded};
			default: resp = SLVERR;
		endcase
	endtask

	function automatic logic [3:0] direction_nibble(input player_t p);
		return {p.left, p.right, p.up, p.down};
	endfunction

	// Pressed is 1 here, the whole word is inverted on return.
	function automatic inp_bytes_t expected_inp(input panel_t p, input logic four);
		inp_bytes_t e;
		if (four) begin
			e.inp0 = {direction_nibble(p.pl[0]), direction_nibble(p.pl[1])};
			e.inp1 = {direction_nibble(p.pl[2]), direction_nibble(p.pl[3])};
			e.inp2 = {p.pl[2].fire_a | p.pl[3].fire_a, p.pl[0].fire_a | p.pl[1].fire_a,
				p.start2, p.start1, 3'b000, p.coin};
		end else begin
			e.inp0 = {direction_nibble(p.pl[0]), 1'b0, p.pl[0].fire_b, p.pl[0].fire_a,
				p.pl[0].fire_c};
			e.inp1 = {direction_nibble(p.pl[1]), 1'b0, p.pl[1].fire_b, p.pl[1].fire_a,
				p.pl[1].fire_c};
			e.inp2 = {2'b00, p.start2, p.start1, 3'b000, p.coin};
		end
		return ~e;
	endfunction

	// Returns on the falling edge where bvalid is seen.
	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output axi_resp_e resp);
		int n;
		axil_req.awaddr = addr;
		axil_req.wdata = data;
		axil_req.wstrb = strb;
		axil_req.awvalid = 1'b1;
		axil_req.wvalid = 1'b1;
		axil_req.bready = 1'b1;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
			if (n > HS_LIMIT) abort_run("AXI write got no write response");
		end while (!axil_rsp.bvalid);
		resp = axil_rsp.bresp;
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
		output axi_resp_e resp);
		int n;
		axil_req.araddr = addr;
		axil_req.arvalid = 1'b1;
		axil_req.rready = 1'b1;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
			if (n > HS_LIMIT) abort_run("AXI read got no read data");
		end while (!axil_rsp.rvalid);
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		axil_req.arvalid = 1'b0;
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		axi_resp_e resp;
		axi_resp_e exp_resp;
		model_write(addr, data, strb, exp_resp);
		axi_write(addr, data, strb, resp);
		check_resp("bresp", resp, exp_resp);
	endtask

	task automatic reg_readback(input logic [3:0] addr);
		logic [31:0] got;
		logic [31:0] exp;
		axi_resp_e resp;
		axi_resp_e exp_resp;
		axi_read(addr, got, resp);
		model_read(addr, exp, exp_resp);
		check_resp("rresp", resp, exp_resp);
		check_word("rdata", got, exp);
	endtask

	// Core port must see FF on every cycle of the download.
	task automatic download_byte(input logic [ROM_ADDR_W-1:0] a, input logic [7:0] d);
		int hold;
		int gap;
		hold = $urandom_range(2, 1);
		gap = $urandom_range(3, 1);
		dl.addr = a;
		dl.data = d;
		dl.wr = 1'b1;
		repeat (hold + gap) begin
			@(negedge clk_sys);
			check_byte("rom_data", rom_data, 8'hFF);
			rom_addr = ROM_ADDR_W'($urandom);
			hold--;
			if (hold == 0) dl.wr = 1'b0;
		end
	endtask

	task automatic run_audio(input logic [AUDIO_W-1:0] s);
		int high;
		logic [AUDIO_W:0] sum;
		sample = s;
		high = 0;
		repeat (AUDIO_PHASE) begin
			@(negedge clk_sys);
			sum = {1'b0, m_acc} + {1'b0, s};
			m_acc = sum[AUDIO_W-1:0];
			check_bit("audio_out", audio_out, sum[AUDIO_W]);
			if (audio_out) high++;
		end
		check_word("audio high count", 32'(high), 32'(s));
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired before the tests finished");
		$display("Test failed");
		$fatal(1);
	end

	initial begin
		logic [31:0] rnd;
		logic [3:0] addr;
		logic [ROM_ADDR_W-1:0] a;
		logic [7:0] d;
		void'($urandom(32'h4493));
		rst = 1'b1;
		axil_req = '0;
		dl = '0;
		rom_addr = '0;
		panel = '1; // Everything pressed while in reset.
		sample = '0;
		repeat (RESET_CYCLES) @(negedge clk_sys);

		check_inp("inp", inp, '1);
		check_bit("core_reset", core_reset, 1'b1);
		check_bit("audio_out", audio_out, 1'b0);
		rst = 1'b0;
		panel = '0;
		@(negedge clk_sys);
		reg_readback(REG_INFO);

		for (int i = 0; i < N_REG_OPS; i++) begin
			case ($urandom_range(5, 0))
				0: addr = REG_STATUS;
				1: addr = REG_DSW;
				2: addr = REG_MODE;
				3: addr = REG_INFO;
				default: addr = 4'($urandom);
			endcase
			write_reg(addr, $urandom, 4'($urandom));
			reg_readback(addr);
			reg_readback(4'($urandom));
			check_byte("dsw0", dsw0, m_dsw[7:0]);
			check_byte("dsw1", dsw1, m_dsw[15:8]);
		end

		write_reg(REG_STATUS, 32'h0, 4'h1);
		dl.active = 1'b1;
		reg_readback(REG_INFO);
		for (int i = 0; i < N_BYTES; i++) begin
			a = ROM_ADDR_W'($urandom);
			d = 8'($urandom);
			if (!img_set[a]) img_addrs.push_back(a);
			img_set[a] = 1'b1;
			img[a] = d;
			download_byte(a, d);
		end
		dl.active = 1'b0;
		@(negedge clk_sys);
		m_loaded = 1'b1;
		check_bit("rom_loaded", UUT.rom_loaded, 1'b1);
		check_bit("core_reset", core_reset, 1'b1);
		@(negedge clk_sys);
		check_bit("core_reset", core_reset, 1'b0);
		reg_readback(REG_INFO);
		foreach (img_addrs[i]) begin
			rom_addr = ROM_ADDR_W'(img_addrs[i]);
			@(negedge clk_sys);
			check_byte("rom_data", rom_data, img[img_addrs[i]]);
		end

		write_reg(REG_STATUS, 32'h1, 4'h1);
		check_bit("core_reset", core_reset, 1'b0);
		@(negedge clk_sys);
		check_bit("core_reset", core_reset, 1'b1);
		write_reg(REG_STATUS, 32'h0, 4'h1);
		check_bit("core_reset", core_reset, 1'b1);
		@(negedge clk_sys);
		check_bit("core_reset", core_reset, 1'b0);

		for (int m = 1; m >= 0; m--) begin
			write_reg(REG_MODE, 32'(m), 4'h1);
			repeat (N_PANELS) begin
				rnd = $urandom;
				panel = rnd[$bits(panel_t)-1:0];
				@(negedge clk_sys);
				check_inp("inp", inp, expected_inp(panel, m_mode));
			end
		end

		repeat (N_SAMPLES) run_audio(AUDIO_W'($urandom));

		$display("Test passed");
		$finish;
	end

endmodule

/* rtl/arcade_shell_top.sv */
`timescale 1ns/10ps

module arcade_shell_top (
	input logic clk_sys,
	input logic rst,
	input arcade_pkg::axil_req_t axil_req,
	output arcade_pkg::axil_rsp_t axil_rsp,
	input arcade_pkg::dl_byte_t dl,
	input logic [arcade_pkg::ROM_ADDR_W-1:0] rom_addr,
	output logic [7:0] rom_data,
	input arcade_pkg::panel_t panel,
	output arcade_pkg::inp_bytes_t inp,
	output logic [7:0] dsw0,
	output logic [7:0] dsw1,
	output logic core_reset,
	input logic [arcade_pkg::AUDIO_W-1:0] sample,
	output logic audio_out
);
	import arcade_pkg::*;

	cfg_t cfg;
	rom_wr_t rom_wr;
	logic rom_loaded;

	assign dsw0 = cfg.dsw0;
	assign dsw1 = cfg.dsw1;

	arcade_cfg_regs u_cfg_regs (
		.clk_sys(clk_sys),
		.rst(rst),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.cfg(cfg),
		.rom_loaded(rom_loaded),
		.dl_active(dl.active)
	);

	rom_loader u_rom_loader (
		.clk_sys(clk_sys),
		.rst(rst),
		.dl(dl),
		.soft_reset(cfg.soft_reset),
		.rom_wr(rom_wr),
		.rom_loaded(rom_loaded),
		.core_reset(core_reset)
	);

	rom_store u_rom_store (
		.clk_sys(clk_sys),
		.rom_wr(rom_wr),
		.dl_active(dl.active),
		.rom_addr(rom_addr),
		.rom_data(rom_data)
	);

	input_mapper u_input_mapper (
		.clk_sys(clk_sys),
		.rst(rst),
		.four_ctrl(cfg.four_ctrl),
		.panel(panel),
		.inp(inp)
	);

	audio_dac u_audio_dac (
		.clk_sys(clk_sys),
		.rst(rst),
		.sample(sample),
		.audio_out(audio_out)
	);

endmodule

/* rtl/audio_dac.sv */
`timescale 1ns/10ps

module audio_dac (
	input logic clk_sys,
	input logic rst,
	input logic [arcade_pkg::AUDIO_W-1:0] sample,
	output logic audio_out
);
	import arcade_pkg::*;

	logic [AUDIO_W-1:0] acc;
	logic [AUDIO_W:0] sum;

	assign sum = {1'b0, acc} + {1'b0, sample};

	// Carry out density tracks sample / 2**AUDIO_W.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			acc <= '0;
			audio_out <= 1'b0;
		end else begin
			acc <= sum[AUDIO_W-1:0];
			audio_out <= sum[AUDIO_W];
		end
	end

endmodule

/* rtl/input_mapper.sv */
`timescale 1ns/10ps

module input_mapper (
	input logic clk_sys,
	input logic rst,
	input logic four_ctrl,
	input arcade_pkg::panel_t panel,
	output arcade_pkg::inp_bytes_t inp
);
	import arcade_pkg::*;

	inp_bytes_t inp_next;
	player_t p1;
	player_t p2;
	player_t p3;
	player_t p4;

	assign p1 = panel.pl[0];
	assign p2 = panel.pl[1];
	assign p3 = panel.pl[2];
	assign p4 = panel.pl[3];

	always_comb begin
		if (four_ctrl) begin
			// Directions only, one nibble per player.
			inp_next.inp0 = ~{p1.left, p1.right, p1.up, p1.down,
				p2.left, p2.right, p2.up, p2.down};
			inp_next.inp1 = ~{p3.left, p3.right, p3.up, p3.down,
				p4.left, p4.right, p4.up, p4.down};
			inp_next.inp2 = ~{p3.fire_a | p4.fire_a, p1.fire_a | p2.fire_a,
				panel.start2, panel.start1, 3'b000, panel.coin};
		end else begin
			inp_next.inp0 = ~{p1.left, p1.right, p1.up, p1.down,
				1'b0, p1.fire_b, p1.fire_a, p1.fire_c};
			inp_next.inp1 = ~{p2.left, p2.right, p2.up, p2.down,
				1'b0, p2.fire_b, p2.fire_a, p2.fire_c};
			inp_next.inp2 = ~{2'b00, panel.start2, panel.start1, 3'b000, panel.coin};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) inp <= '1; // Active low, nothing pressed.
		else inp <= inp_next;
	end

endmodule

/* rtl/rom_store.sv */
`timescale 1ns/10ps

module rom_store (
	input logic clk_sys,
	input arcade_pkg::rom_wr_t rom_wr,
	input logic dl_active,
	input logic [arcade_pkg::ROM_ADDR_W-1:0] rom_addr,
	output logic [7:0] rom_data
);
	import arcade_pkg::*;

	logic [15:0] mem [ROM_WORDS];
	logic [15:0] rd_word;
	logic rd_hi;
	logic rd_block;

	always_ff @(posedge clk_sys) begin
		if (rom_wr.en) begin
			if (rom_wr.be[0]) mem[rom_wr.addr][7:0] <= rom_wr.data[7:0];
			if (rom_wr.be[1]) mem[rom_wr.addr][15:8] <= rom_wr.data[15:8];
		end
	end

	// Registered read, byte picked afterwards.
	always_ff @(posedge clk_sys) begin
		rd_word <= mem[rom_addr[ROM_ADDR_W-1:1]];
		rd_hi <= rom_addr[0];
		rd_block <= dl_active;
	end

	always_comb begin
		if (rd_block) rom_data = 8'hFF; // Core sees open bus while loading.
		else if (rd_hi) rom_data = rd_word[15:8];
		else rom_data = rd_word[7:0];
	end

endmodule

/* rtl/rom_loader.sv */
`timescale 1ns/10ps

module rom_loader (
	input logic clk_sys,
	input logic rst,
	input arcade_pkg::dl_byte_t dl,
	input logic soft_reset,
	output arcade_pkg::rom_wr_t rom_wr,
	output logic rom_loaded,
	output logic core_reset
);
	import arcade_pkg::*;

	logic wr_last;
	logic active_last;
	logic wr_rise;

	assign wr_rise = dl.active && dl.wr && !wr_last;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_last <= 1'b0;
			active_last <= 1'b0;
			rom_wr.en <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1; // Core held until an image is in.
		end else begin
			wr_last <= dl.wr;
			active_last <= dl.active;
			rom_wr.en <= wr_rise;
			if (active_last && !dl.active) rom_loaded <= 1'b1;
			core_reset <= soft_reset || !rom_loaded;
		end
	end

	// Low address bit picks the byte lane.
	always_ff @(posedge clk_sys) begin
		if (wr_rise) begin
			rom_wr.addr <= dl.addr[ROM_ADDR_W-1:1];
			rom_wr.be <= {dl.addr[0], !dl.addr[0]};
			rom_wr.data <= {dl.data, dl.data};
		end
	end

	a_single_write: assert property (@(posedge clk_sys) disable iff (rst)
		rom_wr.en |=> !rom_wr.en);

endmodule

/* rtl/arcade_cfg_regs.sv */
`timescale 1ns/10ps

module arcade_cfg_regs (
	input logic clk_sys,
	input logic rst,
	input arcade_pkg::axil_req_t axil_req,
	output arcade_pkg::axil_rsp_t axil_rsp,
	output arcade_pkg::cfg_t cfg,
	input logic rom_loaded,
	input logic dl_active
);
	import arcade_pkg::*;

	wr_state_e wr_state;
	logic wr_take;
	logic wr_ok;
	axi_resp_e bresp;
	logic rvalid;
	logic [AXIL_DATA_W-1:0] rdata;
	axi_resp_e rresp;
	logic [AXIL_DATA_W-1:0] rd_data;
	axi_resp_e rd_resp;

	// Address and data are only taken together.
	assign wr_take = (wr_state == W_IDLE) && axil_req.awvalid && axil_req.wvalid;

	always_comb begin
		case (axil_req.awaddr)
			REG_STATUS, REG_DSW, REG_MODE: wr_ok = 1'b1;
			default: wr_ok = 1'b0; // INFO is read only.
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_state <= W_IDLE;
			cfg <= '0;
		end else begin
			case (wr_state)
				W_IDLE: if (wr_take) wr_state <= W_RESP;
				W_RESP: if (axil_req.bready) wr_state <= W_IDLE;
				default: wr_state <= W_IDLE;
			endcase
			if (wr_take) begin
				case (axil_req.awaddr)
					REG_STATUS: if (axil_req.wstrb[0]) cfg.soft_reset <= axil_req.wdata[0];
					REG_DSW: begin
						if (axil_req.wstrb[0]) cfg.dsw0 <= axil_req.wdata[7:0];
						if (axil_req.wstrb[1]) cfg.dsw1 <= axil_req.wdata[15:8];
					end
					REG_MODE: if (axil_req.wstrb[0]) cfg.four_ctrl <= axil_req.wdata[0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_take) bresp <= wr_ok ? OKAY : SLVERR;
	end

	always_comb begin
		rd_data = '0;
		rd_resp = OKAY;
		case (axil_req.araddr)
			REG_STATUS: rd_data[0] = cfg.soft_reset;
			REG_DSW: rd_data[15:0] = {cfg.dsw1, cfg.dsw0};
			REG_MODE: rd_data[0] = cfg.four_ctrl;
			REG_INFO: rd_data[1:0] = {dl_active, rom_loaded};
			default: rd_resp = SLVERR;
		endcase
	end

	// One-deep read response.
	always_ff @(posedge clk_sys) begin
		if (rst) rvalid <= 1'b0;
		else if (axil_req.arvalid && !rvalid) rvalid <= 1'b1;
		else if (axil_req.rready) rvalid <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (axil_req.arvalid && !rvalid) begin
			rdata <= rd_data;
			rresp <= rd_resp;
		end
	end

	assign axil_rsp.awready = wr_take;
	assign axil_rsp.wready = wr_take;
	assign axil_rsp.bvalid = (wr_state == W_RESP);
	assign axil_rsp.bresp = bresp;
	assign axil_rsp.arready = !rvalid;
	assign axil_rsp.rvalid = rvalid;
	assign axil_rsp.rdata = rdata;
	assign axil_rsp.rresp = rresp;

	a_bvalid_hold: assert property (@(posedge clk_sys) disable iff (rst)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid);
	a_rvalid_hold: assert property (@(posedge clk_sys) disable iff (rst)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata));

endmodule

/* rtl/arcade_pkg.sv */
package arcade_pkg;

	localparam int ROM_ADDR_W = 17; // Byte address, 128 KiB image.
	localparam int ROM_WORDS = 2 ** (ROM_ADDR_W - 1);
	localparam int AUDIO_W = 16;
	localparam int AXIL_ADDR_W = 4;
	localparam int AXIL_DATA_W = 32;

	// Register offsets on the configuration bus.
	typedef enum logic [AXIL_ADDR_W-1:0] {
		REG_STATUS = 4'd0,
		REG_DSW = 4'd4,
		REG_MODE = 4'd8,
		REG_INFO = 4'd12
	} cfg_reg_e;

	typedef enum logic [1:0] {
		OKAY = 2'b00,
		SLVERR = 2'b10
	} axi_resp_e;

	typedef enum logic {
		W_IDLE,
		W_RESP
	} wr_state_e;

	typedef struct packed {
		logic awvalid;
		logic [AXIL_ADDR_W-1:0] awaddr;
		logic wvalid;
		logic [AXIL_DATA_W-1:0] wdata;
		logic [AXIL_DATA_W/8-1:0] wstrb;
		logic bready;
		logic arvalid;
		logic [AXIL_ADDR_W-1:0] araddr;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		axi_resp_e bresp;
		logic arready;
		logic rvalid;
		logic [AXIL_DATA_W-1:0] rdata;
		axi_resp_e rresp;
	} axil_rsp_t;

	typedef struct packed {
		logic soft_reset;
		logic [7:0] dsw0;
		logic [7:0] dsw1;
		logic four_ctrl;
	} cfg_t;

	typedef struct packed {
		logic active;
		logic wr;
		logic [ROM_ADDR_W-1:0] addr;
		logic [7:0] data;
	} dl_byte_t;

	typedef struct packed {
		logic en;
		logic [ROM_ADDR_W-2:0] addr; // Word address.
		logic [1:0] be;
		logic [15:0] data;
	} rom_wr_t;

	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic fire_a;
		logic fire_b;
		logic fire_c;
	} player_t;

	typedef struct packed {
		player_t [3:0] pl; // pl[0] is player 1.
		logic coin;
		logic start1;
		logic start2;
	} panel_t;

	typedef struct packed {
		logic [7:0] inp0;
		logic [7:0] inp1;
		logic [7:0] inp2;
	} inp_bytes_t;

endpackage
